//--- ltssmPkg.sv
package ltssmPkg;

    // Symbol and count widths
    typedef logic [7:0]   byte_t;
    typedef logic [127:0] orderedSet_t;      // 16 symbols, symbol 0 in bits 7:0
    typedef logic [3:0]   tsCount_t;

    // Start symbols
    localparam byte_t COM_SYM      = 8'hBC;
    localparam byte_t GEN3_TS1_SYM = 8'h1E;
    localparam byte_t GEN3_TS2_SYM = 8'h2D;
    localparam byte_t IDLE_SYM     = 8'h00;

    localparam byte_t PAD_SYM = 8'hF7;
    localparam byte_t TS1_ID  = 8'h2A;
    localparam byte_t TS2_ID  = 8'h25;

    // Symbol positions inside a set
    localparam int START_POS = 0;
    localparam int LINK_POS  = 1;
    localparam int LANE_POS  = 2;
    localparam int RATE_POS  = 4;
    localparam int CTRL_POS  = 5;
    localparam int ID_POS    = 10;

    // Training control bits
    localparam int UPCFG_BIT    = 2;         // Upconfigure capable
    localparam int POLL_CTL_BIT = 3;         // Gates TS1 acceptance in Polling.Active

    // Substate codes from the main LTSSM; detect codes are not checked
    typedef enum logic [3:0] {
        detectQuiet                  = 4'd0,
        detectActive                 = 4'd1,
        pollingActive                = 4'd2,
        pollingConfiguration         = 4'd3,
        configurationLinkWidthStart  = 4'd4,
        configurationLinkWidthAccept = 4'd5,
        configurationLanenumWait     = 4'd6,
        configurationLanenumAccept   = 4'd7,
        configurationComplete        = 4'd8,
        configurationIdle            = 4'd9
    } substate_t;

    typedef struct packed {
        byte_t link;
        byte_t lane;
        byte_t rateId;
        byte_t trainCtl;
        logic  isTs1;
        logic  isTs2;
        logic  isIdle;
    } tsFields_t;

    localparam int COUNT_TARGET_DEFAULT = 8;

endpackage

//--- osCheckFsm.sv
module osCheckFsm #(
    parameter bit UPSTREAM = 1'b0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  ltssmPkg::substate_t substate,
    input  logic                match,
    input  logic                changed,
    output logic                learn,
    output logic                clear,
    output logic                advance
);

    typedef enum logic [1:0] {
        IDLE,
        HUNT,
        TRACK
    } fsmState_t;

    fsmState_t           state;
    fsmState_t           nextState;
    ltssmPkg::substate_t lastSubstate;
    logic                unchecked;
    logic                substateChanged;
    logic                goodSet;
    logic                inComplete;

    assign unchecked = (substate < ltssmPkg::pollingActive) ||
                       (substate > ltssmPkg::configurationIdle);
    assign substateChanged = (substate != lastSubstate);
    assign inComplete = (substate == ltssmPkg::configurationComplete);

    // A rate or upconfigure change breaks the run in Configuration.Complete
    assign goodSet = match && !(inComplete && changed);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state        <= IDLE;
            lastSubstate <= ltssmPkg::detectQuiet;
        end
        else
        begin
            state        <= nextState;
            lastSubstate <= substate;
        end
    end

    always_comb
    begin
        nextState = state;
        learn     = 1'b0;
        clear     = 1'b0;
        advance   = 1'b0;

        if (substateChanged || unchecked)
        begin
            // Restart the search and drop this cycle's set
            clear     = 1'b1;
            nextState = unchecked ? IDLE : HUNT;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    nextState = HUNT;
                end
                HUNT:
                begin
                    if (valid && goodSet)
                    begin
                        advance   = 1'b1;
                        learn     = UPSTREAM &&
                                    (substate == ltssmPkg::configurationLinkWidthStart);
                        nextState = TRACK;
                    end
                end
                TRACK:
                begin
                    if (valid)
                    begin
                        if (goodSet)
                            advance = 1'b1;
                        else
                        begin
                            clear     = 1'b1;   // Run broken
                            nextState = HUNT;
                        end
                    end
                end
                default:
                begin
                    clear     = 1'b1;
                    nextState = IDLE;
                end
            endcase
        end
    end

endmodule

//--- osChecker.sv
module osChecker #(
    parameter bit UPSTREAM     = 1'b0,
    parameter int COUNT_TARGET = ltssmPkg::COUNT_TARGET_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  ltssmPkg::orderedSet_t orderedSet,
    input  ltssmPkg::substate_t   substate,
    input  ltssmPkg::byte_t       linkNumber,
    input  ltssmPkg::byte_t       laneNumber,
    output ltssmPkg::tsCount_t    tsCount,
    output logic                  countDone,
    output ltssmPkg::byte_t       rateId,
    output ltssmPkg::byte_t       linkNumberOut,
    output logic                  upconfigureCapable
);

    ltssmPkg::tsFields_t fields;
    logic                changed;
    logic                match;
    logic                learn;
    logic                clear;
    logic                advance;

    osFieldDecoder decoder_i (
        .orderedSet (orderedSet),
        .fields     (fields)
    );

    osHistory history_i (
        .clk                (clk),
        .reset              (reset),
        .valid              (valid),
        .fields             (fields),
        .changed            (changed),
        .rateId             (rateId),
        .linkNumberOut      (linkNumberOut),
        .upconfigureCapable (upconfigureCapable)
    );

    tsRuleMatch #(.UPSTREAM(UPSTREAM)) ruleMatch_i (
        .clk        (clk),
        .reset      (reset),
        .fields     (fields),
        .substate   (substate),
        .linkNumber (linkNumber),
        .laneNumber (laneNumber),
        .learn      (learn),
        .clear      (clear),
        .match      (match)
    );

    osCheckFsm #(.UPSTREAM(UPSTREAM)) fsm_i (
        .clk      (clk),
        .reset    (reset),
        .valid    (valid),
        .substate (substate),
        .match    (match),
        .changed  (changed),
        .learn    (learn),
        .clear    (clear),
        .advance  (advance)
    );

    tsCounter #(.COUNT_TARGET(COUNT_TARGET)) counter_i (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .clear     (clear),
        .tsCount   (tsCount),
        .countDone (countDone)
    );

endmodule

//--- osChecker_patterns.txt
# name substate valid linkNumber laneNumber orderedSet(symbol 15 down to 0) expCount expDone
# substate 2 pollAct, 3 pollCfg, 6 lanenumWait, 7 lanenumAccept, 8 cfgComplete, 9 cfgIdle
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 0 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 1 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F71E 2 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 3 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F71E 4 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 5 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F71E 6 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 7 0
polla_count 2 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F71E 8 1
polla_sat 2 1 05 03 2A2A2A2A2A2A2A2A2A2A0C0210F7F7BC 8 1
pollcfg_clear 3 0 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 0 0
pollcfg_clear 3 1 05 03 25252525252525252525000210F7F7BC 1 0
pollcfg_clear 3 1 05 03 25252525252525252525000210F7F72D 2 0
pollcfg_clear 3 0 05 03 25252525252525252525000210F7F7BC 2 0
pollcfg_clear 3 1 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 0 0
pollcfg_clear 3 1 05 03 25252525252525252525000210F7F7BC 1 0
pollcfg_clear 3 1 05 03 25252525252525252525000210F701BC 0 0
lanewait_ds 6 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 0 0
lanewait_ds 6 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 1 0
lanewait_ds 6 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100405BC 0 0
lanewait_ds 6 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 1 0
lanewait_ds 6 1 05 03 252525252525252525250002100305BC 0 0
laneacc_ds 7 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 0 0
laneacc_ds 7 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 1 0
laneacc_ds 7 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100306BC 0 0
complete_rate 8 1 05 03 252525252525252525250002100305BC 0 0
complete_rate 8 1 05 03 252525252525252525250002100305BC 1 0
complete_rate 8 1 05 03 252525252525252525250002100305BC 2 0
complete_rate 8 1 05 03 252525252525252525250003100305BC 0 0
complete_rate 8 1 05 03 252525252525252525250403100305BC 0 0
complete_rate 8 1 05 03 252525252525252525250403100305BC 1 0
complete_rate 8 1 05 03 2A2A2A2A2A2A2A2A2A2A0002100305BC 0 0
idle_data 9 1 05 03 00000000000000000000000000000000 0 0
idle_data 9 1 05 03 00000000000000000000000000000000 1 0
idle_data 9 1 05 03 00000000000000000000000000000000 2 0
idle_data 2 0 05 03 2A2A2A2A2A2A2A2A2A2A000210F7F7BC 0 0

//--- osChecker_tb.sv
module osChecker_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int SPARE_CYCLES = 20;

    // One line of the pattern file
    typedef struct packed {
        ltssmPkg::substate_t   substate;
        logic                  valid;
        ltssmPkg::byte_t       linkNumber;
        ltssmPkg::byte_t       laneNumber;
        ltssmPkg::orderedSet_t orderedSet;
        ltssmPkg::tsCount_t    expCount;
        logic                  expDone;
    } pattern_t;

    logic                  clk;
    logic                  reset;
    logic                  valid;
    ltssmPkg::orderedSet_t orderedSet;
    ltssmPkg::substate_t   substate;
    ltssmPkg::byte_t       linkNumber;
    ltssmPkg::byte_t       laneNumber;
    ltssmPkg::tsCount_t    tsCount;
    logic                  countDone;
    ltssmPkg::byte_t       rateId;
    ltssmPkg::byte_t       linkNumberOut;
    logic                  upconfigureCapable;

    pattern_t              patterns[$];
    string                 names[$];
    ltssmPkg::orderedSet_t lastSet;
    int                    cycles = 0;
    int                    cycleLimit = 0;

    tbClock #(.RESET_CYCLES(RESET_CYCLES)) clock_i (
        .clk   (clk),
        .reset (reset)
    );

    osChecker #(.UPSTREAM(1'b0), .COUNT_TARGET(8)) dut_i (
        .clk                (clk),
        .reset              (reset),
        .valid              (valid),
        .orderedSet         (orderedSet),
        .substate           (substate),
        .linkNumber         (linkNumber),
        .laneNumber         (laneNumber),
        .tsCount            (tsCount),
        .countDone          (countDone),
        .rateId             (rateId),
        .linkNumberOut      (linkNumberOut),
        .upconfigureCapable (upconfigureCapable)
    );

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic readPatterns();
        int                    fd;
        int                    got;
        string                 name;
        string                 rest;
        logic [3:0]            sub;
        logic                  v;
        logic                  done;
        ltssmPkg::byte_t       link;
        ltssmPkg::byte_t       lane;
        ltssmPkg::orderedSet_t os;
        ltssmPkg::tsCount_t    cnt;
        fd = $fopen("osChecker_patterns.txt", "r");
        if (fd == 0)
            stopWithError("Could not open osChecker_patterns.txt");
        while ($fscanf(fd, "%s", name) == 1)
        begin
            if (name.getc(0) == "#")
                got = $fgets(rest, fd);   // Comment line
            else
            begin
                got = $fscanf(fd, "%h %h %h %h %h %h %h", sub, v, link, lane, os, cnt, done);
                if (got != 7)
                    stopWithError("A pattern line has missing columns");
                patterns.push_back({ltssmPkg::substate_t'(sub), v, link, lane, os, cnt, done});
                names.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyPattern(input pattern_t p);
        substate   <= p.substate;
        valid      <= p.valid;
        linkNumber <= p.linkNumber;
        laneNumber <= p.laneNumber;
        orderedSet <= p.orderedSet;
    endtask

    task automatic checkOutputs(input string testName, input pattern_t p);
        if (p.valid)
            lastSet = p.orderedSet;
        checkValue(testName, "tsCount", 32'(p.expCount), 32'(tsCount));
        checkValue(testName, "countDone", 32'(p.expDone), 32'(countDone));
        // Rate ID is symbol 4, link symbol 1, upconfigure bit 2 of symbol 5
        checkValue(testName, "rateId", 32'(lastSet[39:32]), 32'(rateId));
        checkValue(testName, "linkNumberOut", 32'(lastSet[15:8]), 32'(linkNumberOut));
        checkValue(testName, "upconfigureCapable", 32'(lastSet[42]), 32'(upconfigureCapable));
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, the patterns did not finish", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        valid      = 1'b0;
        orderedSet = '0;
        substate   = ltssmPkg::detectQuiet;
        linkNumber = '0;
        laneNumber = '0;
        lastSet    = '0;
        readPatterns();
        if (patterns.size() == 0)
            stopWithError("No pattern lines were read");
        cycleLimit = patterns.size() + RESET_CYCLES + SPARE_CYCLES;
        wait (reset === 1'b1);
        // Outputs for line i-1 are settled at the falling edge after line i goes out
        for (int i = 0; i <= patterns.size(); i++)
        begin
            @(posedge clk);
            if (i < patterns.size())
                applyPattern(patterns[i]);
            else
                valid <= 1'b0;
            @(negedge clk);
            if (i > 0)
                checkOutputs(names[i-1], patterns[i-1]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- osFieldDecoder.sv
module osFieldDecoder (
    input  ltssmPkg::orderedSet_t orderedSet,
    output ltssmPkg::tsFields_t   fields
);

    ltssmPkg::byte_t startSym;
    ltssmPkg::byte_t idSym;
    logic            ts1Start;
    logic            ts2Start;

    // Symbol n sits in bits 8n+7 down to 8n
    function automatic ltssmPkg::byte_t symbolAt(
        input ltssmPkg::orderedSet_t os,
        input int                    pos
    );
        return os[pos*8 +: 8];
    endfunction

    assign startSym = symbolAt(orderedSet, ltssmPkg::START_POS);
    assign idSym    = symbolAt(orderedSet, ltssmPkg::ID_POS);

    // 8b/10b sets start with COM, 128b/130b sets with their own symbol
    assign ts1Start = (startSym == ltssmPkg::COM_SYM) ||
                      (startSym == ltssmPkg::GEN3_TS1_SYM);
    assign ts2Start = (startSym == ltssmPkg::COM_SYM) ||
                      (startSym == ltssmPkg::GEN3_TS2_SYM);

    always_comb
    begin
        fields.link     = symbolAt(orderedSet, ltssmPkg::LINK_POS);
        fields.lane     = symbolAt(orderedSet, ltssmPkg::LANE_POS);
        fields.rateId   = symbolAt(orderedSet, ltssmPkg::RATE_POS);
        fields.trainCtl = symbolAt(orderedSet, ltssmPkg::CTRL_POS);
        fields.isTs1    = ts1Start && (idSym == ltssmPkg::TS1_ID);
        fields.isTs2    = ts2Start && (idSym == ltssmPkg::TS2_ID);
        fields.isIdle   = (startSym == ltssmPkg::IDLE_SYM);   // Logical idle data
    end

endmodule

//--- osHistory.sv
module osHistory (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  ltssmPkg::tsFields_t fields,
    output logic                changed,
    output ltssmPkg::byte_t     rateId,
    output ltssmPkg::byte_t     linkNumberOut,
    output logic                upconfigureCapable
);

    ltssmPkg::tsFields_t last;
    logic                rateDiff;
    logic                upcfgDiff;

    // Fields of the last valid set
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            last <= '0;
        else if (valid)
            last <= fields;
    end

    assign rateDiff  = (fields.rateId != last.rateId);
    assign upcfgDiff = fields.trainCtl[ltssmPkg::UPCFG_BIT] !=
                       last.trainCtl[ltssmPkg::UPCFG_BIT];

    // Stability only counts against a stored TS2
    assign changed = last.isTs2 && (rateDiff || upcfgDiff);

    assign rateId             = last.rateId;
    assign linkNumberOut      = last.link;
    assign upconfigureCapable = last.trainCtl[ltssmPkg::UPCFG_BIT];

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module osChecker_tb -f vlog.f -o osChecker_sim

./obj_dir/osChecker_sim 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tbClock.sv
module tbClock #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;   // Flops see the release on the following edge
    end

endmodule

//--- tsCounter.sv
module tsCounter #(
    parameter int COUNT_TARGET = ltssmPkg::COUNT_TARGET_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    input  logic               clear,
    output ltssmPkg::tsCount_t tsCount,
    output logic               countDone
);

    localparam ltssmPkg::tsCount_t TARGET = ltssmPkg::tsCount_t'(COUNT_TARGET);

    logic atTarget;

    assign atTarget = (tsCount == TARGET);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            tsCount <= '0;
        end
        else if (clear)
        begin
            tsCount <= '0;
        end
        else if (advance && !atTarget)
        begin
            tsCount <= tsCount + 1'b1;   // Holds once the target is reached
        end
    end

    assign countDone = atTarget;

    countBounded: assert property (@(posedge clk) disable iff (!reset)
        tsCount <= TARGET);

endmodule

//--- tsRuleMatch.sv
module tsRuleMatch #(
    parameter bit UPSTREAM = 1'b0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ltssmPkg::tsFields_t  fields,
    input  ltssmPkg::substate_t  substate,
    input  ltssmPkg::byte_t      linkNumber,
    input  ltssmPkg::byte_t      laneNumber,
    input  logic                 learn,
    input  logic                 clear,
    output logic                 match
);

    ltssmPkg::byte_t learnedLink;
    logic            learnedValid;
    logic            linkIsPad;
    logic            laneIsPad;
    logic            linkOk;
    logic            laneOk;
    logic            pollTs1Ok;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            learnedValid <= 1'b0;
        else if (clear)
            learnedValid <= 1'b0;
        else if (learn)
            learnedValid <= 1'b1;
    end

    // Link number offered by the downstream port
    always_ff @(posedge clk)
    begin
        if (learn)
            learnedLink <= fields.link;
    end

    assign linkIsPad = (fields.link == ltssmPkg::PAD_SYM);
    assign laneIsPad = (fields.lane == ltssmPkg::PAD_SYM);
    assign linkOk    = (fields.link == linkNumber);
    assign laneOk    = (fields.lane == laneNumber);
    assign pollTs1Ok = !fields.trainCtl[ltssmPkg::POLL_CTL_BIT] ||
                       fields.trainCtl[ltssmPkg::UPCFG_BIT];

    always_comb
    begin
        match = 1'b0;
        case (substate)
            ltssmPkg::pollingActive:
                match = linkIsPad && laneIsPad &&
                        ((fields.isTs1 && pollTs1Ok) || fields.isTs2);
            ltssmPkg::pollingConfiguration:
                match = fields.isTs2 && linkIsPad && laneIsPad;
            ltssmPkg::configurationLinkWidthStart:
                if (UPSTREAM)
                    match = fields.isTs1 && !linkIsPad && laneIsPad &&
                            (!learnedValid || fields.link == learnedLink);
                else
                    match = fields.isTs1 && linkOk && laneIsPad;
            ltssmPkg::configurationLinkWidthAccept:
                match = UPSTREAM && fields.isTs1 && linkOk && !laneIsPad;   // Downstream never
            ltssmPkg::configurationLanenumWait,
            ltssmPkg::configurationLanenumAccept:
                match = (UPSTREAM ? fields.isTs2 : fields.isTs1) && linkOk && laneOk;
            ltssmPkg::configurationComplete:
                match = fields.isTs2 && linkOk && laneOk;
            ltssmPkg::configurationIdle:
                match = fields.isIdle;
            default:
                match = 1'b0;
        endcase
    end

    // Only an upstream port learns a link number from the far end
    learnOnlyUpstream: assert property (@(posedge clk) disable iff (!reset)
        learn |-> UPSTREAM);

endmodule

//--- vlog.f
ltssmPkg.sv
osFieldDecoder.sv
tsRuleMatch.sv
osHistory.sv
tsCounter.sv
osCheckFsm.sv
osChecker.sv
tbClock.sv
osChecker_tb.sv
